// ==== source/uartPkg.sv ====
/*
 * serial line constants for the 8N1 transmitter and receiver
 * baud timing at 25 MHz, sample offset, frame layout and counter widths
 */

`default_nettype none

package uartPkg;

	localparam int bitCycles = 217; // 115200 baud at 25 MHz
	localparam int halfBit = 108; // start edge to mid-bit sample
	localparam int dataBits = 8; // payload bits, LSB first
	localparam int frameBits = 10; // start + 8 data + stop

	// counter widths derived from the timing above
	localparam int baudWidth = $clog2(bitCycles); // holds 0..216
	localparam int indexWidth = $clog2(frameBits); // holds 0..9

endpackage

`default_nettype wire

// ==== source/busPkg.sv ====
/*
 * register bus constants and register addresses
 * regWord union with the TX status and RX data views of one read word
 */

`default_nettype none

package busPkg;

	localparam int wordWidth = 16; // register word of the host computer
	localparam int clientCount = 2; // console and debug side

	localparam logic addrTx = 1'b0; // write loads a byte, read gives status
	localparam logic addrRx = 1'b1; // read gives data and clears valid

	// status word at addrTx, busy in the top bit like the host expects
	typedef struct packed {
		logic busy; // 1 while a frame is on the line
		logic [14:0] reserved;
	} txStatusView;

	// data word at addrRx
	typedef struct packed {
		logic valid; // unread byte held
		logic overrun; // a byte was lost before the read
		logic [5:0] reserved;
		logic [7:0] data; // last received byte
	} rxDataView;

	typedef union packed {
		txStatusView txStatus;
		rxDataView rxData;
	} regWord;

endpackage

`default_nettype wire

// ==== source/UartTx.sv ====
/*
 * 8N1 serializer
 * start bit, eight data bits LSB first, stop bit, with a busy flag
 */

`timescale 1ns/10ps
`default_nettype none

module UartTx import uartPkg::*; (
	input logic clk,
	input logic reset,
	input logic load, // start a frame with data
	input logic [dataBits-1:0] data, // byte to send
	output logic tx, // serial line, idles high
	output logic busy // high for the whole frame
);

	logic [dataBits:0] shiftReg; // bit 0 drives the line
	logic [baudWidth-1:0] baudCount; // cycles within the current bit
	logic [indexWidth-1:0] bitIndex; // which of the ten bits is out
	logic bitEnd;

	// last cycle of a bit time
	assign bitEnd = busy && (baudCount == baudWidth'(bitCycles - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			baudCount <= '0;
			bitIndex <= '0;
			shiftReg <= '1; // line high out of reset
		end else if (load) begin
			busy <= 1'b1; // rises the cycle after load
			baudCount <= '0;
			bitIndex <= '0;
			shiftReg <= {data, 1'b0}; // low start bit goes out first
		end else if (bitEnd) begin
			baudCount <= '0;
			// shift right, ones fill from the top and become the stop bit
			shiftReg <= {1'b1, shiftReg[dataBits:1]};
			if (bitIndex == indexWidth'(frameBits - 1)) begin
				busy <= 1'b0; // stop bit done, line stays high
				bitIndex <= '0;
			end else begin
				bitIndex <= bitIndex + 1'b1;
			end
		end else if (busy) begin
			baudCount <= baudCount + 1'b1;
		end
	end

	assign tx = shiftReg[0];

endmodule

`default_nettype wire

// ==== source/UartRx.sv ====
/*
 * 8N1 deserializer
 * line synchronizer, start edge detect, mid-bit sampling,
 * stop bit check and a one-cycle strobe per good byte
 */

`timescale 1ns/10ps
`default_nettype none

module UartRx import uartPkg::*; (
	input logic clk,
	input logic reset,
	input logic rx, // asynchronous serial line
	output logic strobe, // one cycle, byte on data is good
	output logic [dataBits-1:0] data
);

	logic rxMeta; // first synchronizer stage
	logic rxSync; // safe to use
	logic rxPrev; // for the falling edge
	logic active; // inside a frame
	logic [baudWidth-1:0] baudCount;
	logic [indexWidth-1:0] bitIndex; // 0 start, 1..8 data, 9 stop
	logic [dataBits-1:0] shiftReg;
	logic sampleNow;

	always_ff @(posedge clk) begin
		if (reset) begin
			rxMeta <= 1'b1; // idle line level
			rxSync <= 1'b1;
			rxPrev <= 1'b1;
		end else begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			rxPrev <= rxSync;
		end
	end

	// first sample half a bit after the edge, then one per bit time
	assign sampleNow = active && ((bitIndex == '0) ? (baudCount == baudWidth'(halfBit))
		: (baudCount == baudWidth'(bitCycles - 1)));

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			baudCount <= '0;
			bitIndex <= '0;
			strobe <= 1'b0;
		end else begin
			strobe <= 1'b0;
			if (!active) begin
				if (rxPrev && !rxSync) begin // falling edge, maybe a start bit
					active <= 1'b1;
					baudCount <= '0;
					bitIndex <= '0;
				end
			end else if (sampleNow) begin
				baudCount <= '0;
				bitIndex <= bitIndex + 1'b1;
				if (bitIndex == '0) begin
					if (rxSync) active <= 1'b0; // high at mid start, a glitch
				end else if (bitIndex == indexWidth'(frameBits - 1)) begin
					active <= 1'b0;
					strobe <= rxSync; // low stop bit drops the frame
				end else begin
					shiftReg <= {rxSync, shiftReg[dataBits-1:1]}; // LSB arrives first
				end
			end else begin
				baudCount <= baudCount + 1'b1;
			end
		end
	end

	// stable until the next frame's first data bit
	assign data = shiftReg;

endmodule

`default_nettype wire

// ==== source/BusArbiter.sv ====
/*
 * round-robin arbiter for two four-phase req/ack clients
 * muxes the granted client onto the shared register port
 */

`timescale 1ns/10ps
`default_nettype none

module BusArbiter import busPkg::*; (
	input logic clk,
	input logic reset,
	input logic [clientCount-1:0] clientReq,
	input logic [clientCount-1:0] clientWrite,
	input logic [clientCount-1:0] clientAddr,
	input logic [wordWidth-1:0] clientWdata [clientCount],
	input logic portAck,
	input logic [wordWidth-1:0] portRdata,
	output logic [clientCount-1:0] clientAck,
	output logic [wordWidth-1:0] clientRdata [clientCount],
	output logic portReq,
	output logic portWrite,
	output logic portAddr,
	output logic [wordWidth-1:0] portWdata
);

	logic granted; // a client owns the port
	logic grantId; // which one
	logic lastServed; // loses the next tie
	logic ackSeen; // port ack came up during this grant
	logic retire; // handshake back at zero
	logic pick;

	// on a tie the client not served last wins
	assign pick = (clientReq[0] && clientReq[1]) ? ~lastServed : clientReq[1];
	assign retire = ackSeen && !portAck;

	always_ff @(posedge clk) begin
		if (reset) begin
			granted <= 1'b0;
			grantId <= 1'b0;
			lastServed <= 1'b1; // client 0 wins the first tie
			ackSeen <= 1'b0;
		end else if (!granted) begin
			if (|clientReq) begin
				granted <= 1'b1; // grant one cycle after req
				grantId <= pick;
				ackSeen <= 1'b0;
			end
		end else if (retire) begin
			granted <= 1'b0;
			lastServed <= grantId;
			ackSeen <= 1'b0;
		end else if (portAck) begin
			ackSeen <= 1'b1;
		end
	end

	// a req raised again in the release cycle waits for a fresh grant
	assign portReq = granted && !retire && clientReq[grantId];
	assign portWrite = clientWrite[grantId];
	assign portAddr = clientAddr[grantId];
	assign portWdata = clientWdata[grantId];

	always_comb begin
		for (int i = 0; i < clientCount; i++) begin
			clientAck[i] = granted && (grantId == i) && portAck; // only the owner sees ack
			clientRdata[i] = (granted && (grantId == i)) ? portRdata : '0;
		end
	end

endmodule

`default_nettype wire

// ==== source/UartRegs.sv ====
/*
 * UART register block behind the shared port
 * TX write with back-pressure, TX status, RX data with valid and overrun
 */

`timescale 1ns/10ps
`default_nettype none

module UartRegs import busPkg::*; (
	input logic clk,
	input logic reset,
	input logic portReq,
	input logic portWrite,
	input logic portAddr,
	input logic [wordWidth-1:0] portWdata,
	input logic txBusy,
	input logic rxStrobe,
	input logic [7:0] rxByte,
	output logic portAck,
	output logic [wordWidth-1:0] portRdata,
	output logic txLoad, // one cycle, together with ack
	output logic [7:0] txByte
);

	logic valid;
	logic overrun;
	logic [7:0] rxHold; // last received byte
	logic txWrite; // request is a write to addrTx
	logic accept; // take the request this cycle
	logic readRx; // accepted read of addrRx
	regWord readWord;

	assign txWrite = portWrite && (portAddr == addrTx);
	assign accept = portReq && !portAck && !(txWrite && txBusy); // hold ack while busy
	assign readRx = accept && !portWrite && (portAddr == addrRx);

	// same word, two decodings by address
	always_comb begin
		readWord = '0;
		if (portAddr == addrTx) begin
			readWord.txStatus.busy = txBusy;
		end else begin
			readWord.rxData.valid = valid;
			readWord.rxData.overrun = overrun;
			readWord.rxData.data = rxHold;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			portAck <= 1'b0;
			txLoad <= 1'b0;
			valid <= 1'b0;
			overrun <= 1'b0;
		end else begin
			txLoad <= accept && txWrite;
			if (accept) portAck <= 1'b1;
			else if (!portReq) portAck <= 1'b0; // drops the cycle after req
			if (rxStrobe) begin
				valid <= 1'b1;
				overrun <= (overrun || valid) && !readRx; // a read this cycle took the old byte
			end else if (readRx) begin
				valid <= 1'b0;
				overrun <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) portRdata <= readWord; // valid while ack is high
		if (accept && txWrite) txByte <= portWdata[7:0];
		if (rxStrobe) rxHold <= rxByte;
	end

endmodule

`default_nettype wire

// ==== source/UartSystem.sv ====
/*
 * UART peripheral top level
 * arbiter, register block, transmitter and receiver
 */

`timescale 1ns/10ps
`default_nettype none

module UartSystem import busPkg::*; (
	input logic clk,
	input logic reset,
	input logic [clientCount-1:0] clientReq, // bit 0 console, bit 1 debug
	input logic [clientCount-1:0] clientWrite,
	input logic [clientCount-1:0] clientAddr,
	input logic [wordWidth-1:0] clientWdata [clientCount],
	output logic [clientCount-1:0] clientAck,
	output logic [wordWidth-1:0] clientRdata [clientCount],
	output logic tx, // serial out
	input logic rx // serial in
);

	// shared register port
	logic portReq;
	logic portWrite;
	logic portAddr;
	logic [wordWidth-1:0] portWdata;
	logic portAck;
	logic [wordWidth-1:0] portRdata;

	// register block to line side
	logic txLoad;
	logic [7:0] txByte;
	logic txBusy;
	logic rxStrobe;
	logic [7:0] rxByte;

	BusArbiter u_BusArbiter (
		.clk(clk),
		.reset(reset),
		.clientReq(clientReq),
		.clientWrite(clientWrite),
		.clientAddr(clientAddr),
		.clientWdata(clientWdata),
		.portAck(portAck),
		.portRdata(portRdata),
		.clientAck(clientAck),
		.clientRdata(clientRdata),
		.portReq(portReq),
		.portWrite(portWrite),
		.portAddr(portAddr),
		.portWdata(portWdata)
	);

	UartRegs u_UartRegs (
		.clk(clk),
		.reset(reset),
		.portReq(portReq),
		.portWrite(portWrite),
		.portAddr(portAddr),
		.portWdata(portWdata),
		.txBusy(txBusy),
		.rxStrobe(rxStrobe),
		.rxByte(rxByte),
		.portAck(portAck),
		.portRdata(portRdata),
		.txLoad(txLoad),
		.txByte(txByte)
	);

	UartTx u_UartTx (
		.clk(clk),
		.reset(reset),
		.load(txLoad),
		.data(txByte),
		.tx(tx),
		.busy(txBusy)
	);

	UartRx u_UartRx (
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.strobe(rxStrobe),
		.data(rxByte)
	);

endmodule

`default_nettype wire

// ==== test/UartSystem_chk.sv ====
/*
 * bus protocol and serial line assertions for the UART top level
 * bound into every UartSystem instance
 */

`timescale 1ns/10ps
`default_nettype none

module UartSystem_chk import busPkg::*; (
	input logic clk,
	input logic reset,
	input logic [clientCount-1:0] clientReq,
	input logic [clientCount-1:0] clientAck,
	input logic txBusy, // internal, from the transmitter
	input logic tx
);

	int failures = 0; // count of failed assertions

	// the arbiter gives the port to one client at a time
	ackExclusive: assert property (@(posedge clk) disable iff (reset) !(&clientAck))
		else begin
			failures++;
			$error("both client acks are high together");
		end

	for (genvar i = 0; i < clientCount; i++) begin : perClient
		// four-phase, ack only answers a live request
		ackRise: assert property (@(posedge clk) disable iff (reset)
			$rose(clientAck[i]) |-> clientReq[i])
			else begin
				failures++;
				$error("ack of client %0d rose without a request", i);
			end
		// return to zero, req goes first
		ackFall: assert property (@(posedge clk) disable iff (reset)
			$fell(clientAck[i]) |-> !clientReq[i])
			else begin
				failures++;
				$error("ack of client %0d fell while its request was high", i);
			end
	end

	lineIdle: assert property (@(posedge clk) disable iff (reset) !txBusy |-> tx)
		else begin
			failures++;
			$error("tx is low while the transmitter is idle");
		end

endmodule

bind UartSystem UartSystem_chk u_UartSystem_chk (
	.clk(clk),
	.reset(reset),
	.clientReq(clientReq),
	.clientAck(clientAck),
	.txBusy(txBusy),
	.tx(tx)
);

`default_nettype wire

// ==== test/UartSystemTb.sv ====
/*
 * testbench for the UART peripheral, tx looped back into rx
 * xorshift stimulus on both bus clients, model of written bytes
 * and RX flags, one report line per test
 */

`timescale 1ns/10ps
`default_nettype none

module UartSystemTb import busPkg::*, uartPkg::*;;

	logic clk;
	logic reset;
	logic [clientCount-1:0] clientReq;
	logic [clientCount-1:0] clientWrite;
	logic [clientCount-1:0] clientAddr;
	logic [wordWidth-1:0] clientWdata [clientCount];
	logic [clientCount-1:0] clientAck;
	logic [wordWidth-1:0] clientRdata [clientCount];
	wire line; // tx looped back into rx

	logic [31:0] randState;
	int cycle;
	int errors;
	int checks;
	int tests;
	int testErrors; // error count when the current test began
	int consumed; // model bytes already read back
	int lastWriteAck; // cycle of the latest TX write ack
	int lastClient; // client of the latest acked transfer
	logic [7:0] lastByte; // what the RX data field should hold
	logic [7:0] sentQ [$]; // bytes in write ack order
	logic [7:0] rxQ [$]; // bytes read back with valid set
	int ackOrder [$]; // client of each TX write ack

	UartSystem u_UartSystem (
		.clk(clk),
		.reset(reset),
		.clientReq(clientReq),
		.clientWrite(clientWrite),
		.clientAddr(clientAddr),
		.clientWdata(clientWdata),
		.clientAck(clientAck),
		.clientRdata(clientRdata),
		.tx(line),
		.rx(line)
	);

	always #5 clk = ~clk; // 10 ns period

	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [31:0] nextRand();
		randState ^= randState << 13;
		randState ^= randState >> 17;
		randState ^= randState << 5;
		return randState;
	endfunction

	// RX word after 'arrived' new frames since the last read
	// more than one means the older ones were lost
	function automatic logic [15:0] expectRx(input int arrived);
		regWord w;
		w = '0;
		if (arrived > 0) begin
			consumed += arrived;
			lastByte = sentQ[consumed-1]; // newest byte wins
		end
		w.rxData.valid = (arrived > 0);
		w.rxData.overrun = (arrived > 1);
		w.rxData.data = lastByte;
		return w;
	endfunction

	task automatic check(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic finishTest(input string name);
		tests++;
		$display("%-14s %s", name, (errors == testErrors) ? "ok" : "has errors");
		testErrors = errors;
	endtask

	// one four-phase transfer, outputs sampled on the falling edge
	task automatic busCycle(input int c, input logic wr, input logic addr,
		input logic [15:0] wdata, output logic [15:0] rdata);
		int waited;
		rdata = 'x;
		@(posedge clk);
		clientWrite[c] <= wr;
		clientAddr[c] <= addr;
		clientWdata[c] <= wdata;
		clientReq[c] <= 1'b1;
		waited = 0;
		do begin // back-pressure can hold ack for a whole frame
			@(negedge clk);
			waited++;
		end while (!clientAck[c] && waited < 3 * frameBits * bitCycles);
		if (!clientAck[c]) begin
			errors++;
			$display("timeout: request of client %0d was never acked", c);
		end else begin
			rdata = clientRdata[c];
			lastClient = c;
			if (wr && addr == addrTx) begin
				sentQ.push_back(wdata[7:0]); // model order is ack order
				ackOrder.push_back(c);
				lastWriteAck = cycle;
			end
		end
		@(posedge clk);
		clientReq[c] <= 1'b0;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (clientAck[c] && waited < 16);
		if (clientAck[c]) begin
			errors++;
			$display("timeout: ack of client %0d stayed high after the request fell", c);
		end
	endtask

	task automatic writeByte(input int c, input logic [7:0] b);
		logic [15:0] unused;
		busCycle(c, 1'b1, addrTx, {8'h00, b}, unused);
	endtask

	task automatic readWord(input int c, input logic addr, output logic [15:0] w);
		busCycle(c, 1'b0, addr, '0, w);
	endtask

	task automatic pollRx(input int c, output logic [15:0] w);
		int tries;
		tries = 0;
		do begin
			readWord(c, addrRx, w);
			tries++;
		end while (w[15] !== 1'b1 && tries < 2000);
		if (w[15] !== 1'b1) begin
			errors++;
			$display("timeout: client %0d never saw a received byte", c);
		end
	endtask

	// busy falls after the stop bit, so every frame has landed by then
	task automatic waitTxIdle(input int c);
		logic [15:0] w;
		int tries;
		tries = 0;
		do begin
			readWord(c, addrTx, w);
			tries++;
		end while (w[15] !== 1'b0 && tries < 2000);
		if (w[15] !== 1'b0) begin
			errors++;
			$display("timeout: transmitter stayed busy");
		end
	endtask

	initial begin
		logic [15:0] w;
		logic [7:0] b0;
		logic [7:0] b1;
		int t1;
		int c;
		int kind;
		int first;
		clk = 1'b0;
		reset = 1'b1;
		clientReq = '0;
		clientWrite = '0;
		clientAddr = '0;
		clientWdata[0] = '0;
		clientWdata[1] = '0;
		randState = 48102;
		cycle = 0;
		errors = 0;
		checks = 0;
		tests = 0;
		testErrors = 0;
		consumed = 0;
		lastWriteAck = 0;
		lastClient = 0;
		lastByte = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		@(negedge clk);
		check("reset tx", 16'h0001, line); // idle line is high
		check("reset acks", 16'h0000, clientAck);
		readWord(0, addrTx, w);
		check("reset status", 16'h0000, w); // busy clear
		finishTest("reset");

		b0 = 8'(nextRand());
		writeByte(0, b0);
		pollRx(0, w);
		check("loopback byte", expectRx(1), w);
		readWord(0, addrRx, w);
		check("loopback clear", expectRx(0), w); // valid gone, byte kept
		finishTest("loopback");

		writeByte(0, 8'(nextRand()));
		t1 = lastWriteAck;
		writeByte(0, 8'(nextRand())); // held until the first frame is out
		check("backpressure gap", 16'h0001, lastWriteAck - t1 >= frameBits * bitCycles);
		readWord(0, addrRx, w); // first byte landed before the second ack
		check("backpressure first", expectRx(1), w);
		pollRx(0, w);
		check("backpressure second", expectRx(1), w);
		finishTest("backpressure");

		ackOrder.delete();
		first = 1 - lastClient; // on a tie the client not served last wins
		b0 = 8'(nextRand());
		b1 = 8'(nextRand());
		fork
			writeByte(0, b0);
			writeByte(1, b1);
		join
		// both served in the first two grants
		check("contention acks", 16'd2, ackOrder.size());
		check("contention priority", first, (ackOrder.size() > 0) ? ackOrder[0] : -1);
		readWord(1, addrRx, w);
		check("contention first", expectRx(1), w);
		pollRx(1, w);
		check("contention second", expectRx(1), w);
		finishTest("contention");

		writeByte(1, 8'(nextRand()));
		writeByte(0, 8'(nextRand()));
		waitTxIdle(0);
		readWord(0, addrRx, w);
		check("overrun word", expectRx(2), w);
		readWord(1, addrRx, w);
		check("overrun clear", expectRx(0), w);
		finishTest("overrun");

		sentQ.delete();
		rxQ.delete();
		consumed = 0;
		repeat (20) begin
			repeat (nextRand() % 8) @(posedge clk); // random gap
			c = nextRand() % 2;
			kind = nextRand() % 3;
			if (kind == 0) begin
				writeByte(c, 8'(nextRand()));
				pollRx(c, w); // drain it so nothing is lost
				check("random rx", expectRx(1), w);
				if (w[15] === 1'b1) rxQ.push_back(w[7:0]);
				waitTxIdle(c);
			end else if (kind == 1) begin
				readWord(c, addrTx, w);
				check("random status", 16'h0000, w);
			end else begin
				readWord(c, addrRx, w);
				check("random empty", expectRx(0), w);
			end
		end
		check("random count", sentQ.size(), rxQ.size());
		foreach (rxQ[i]) check("random order", sentQ[i], rxQ[i]);
		finishTest("random");

		if (u_UartSystem.u_UartSystem_chk.failures != 0) begin
			errors += u_UartSystem.u_UartSystem_chk.failures;
			$display("%0d protocol assertions failed during the run",
				u_UartSystem.u_UartSystem_chk.failures);
		end

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
source/uartPkg.sv
source/busPkg.sv
source/UartTx.sv
source/UartRx.sv
source/BusArbiter.sv
source/UartRegs.sv
source/UartSystem.sv
test/UartSystem_chk.sv
test/UartSystemTb.sv

// ==== Bender.yml ====
package:
  name: uart_system

sources:
  # packages first, then the design bottom up
  - source/uartPkg.sv
  - source/busPkg.sv
  - source/UartTx.sv
  - source/UartRx.sv
  - source/BusArbiter.sv
  - source/UartRegs.sv
  - source/UartSystem.sv
  - target: test
    files:
      - test/UartSystem_chk.sv
      - test/UartSystemTb.sv
